// ==== hw/fp2_exp_pkg.sv ====
/*
  Shared constants and types for the Fp2 exponentiation engine.
  Field is GF(8191), a Mersenne prime with P = 3 mod 4, so u^2 = -1 is valid.
  Every Fp value passed around is assumed to be already reduced below P.
*/
package fp2_exp_pkg;

  // Base field
  localparam int FE_BITS = 13;

  typedef logic [FE_BITS-1:0] fe_t;

  localparam fe_t FE_P = 13'd8191;  // 2^13 - 1

  // Element of Fp2 as re + im*u
  typedef struct packed {
    fe_t re;
    fe_t im;
  } fe2_t;

  // Fixed exponent, walked from bit LOOP_TOP-1 down to bit 0
  localparam logic [15:0] LOOP_X   = 16'hD201;
  localparam int          LOOP_TOP = 15;  // Highest set bit of LOOP_X

  // Depth of the request buffer in front of the multiplier
  localparam int FIFO_DEPTH = 4;

  // Names of the four partial products of one Fp2 step
  typedef enum logic [1:0] {
    TAG_RR,  // re * re
    TAG_II,  // im * im
    TAG_RI,  // re * im
    TAG_IR   // im * re, multiply step only
  } prod_tag_e;

  // Controller FSM
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SQR,   // Issue the three products of f^2
    ST_MUL,   // Issue the four products of f*g
    ST_WAIT,  // Collect products and update f
    ST_OUT
  } ctrl_state_e;

endpackage

// ==== hw/fp_mul_if.sv ====
/*
  One tagged Fp multiply request with a valid/ready handshake.
  The source holds a, b and tag steady while val is high and rdy is low.
*/
`timescale 1ns/1ps

interface fp_mul_if import fp2_exp_pkg::*; ();

  logic      val;
  logic      rdy;
  fe_t       a;
  fe_t       b;
  prod_tag_e tag;  // Travels with the product back to the requester

  modport source (
    output val,
    output a,
    output b,
    output tag,
    input  rdy
  );

  modport sink (
    input  val,
    input  a,
    input  b,
    input  tag,
    output rdy
  );

endinterface

// ==== hw/fp2_exp_ctrl.sv ====
/*
  Square-and-multiply controller computing g^LOOP_X over Fp2.
  All results must be accepted on arrival, there is no ready on the result path.
  Inputs above P-1 give undefined results.
*/
`timescale 1ns/1ps

module fp2_exp_ctrl import fp2_exp_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  // Input element
  input  logic      i_val,
  output logic      o_rdy,
  input  fe2_t      i_g,
  // Result element
  output logic      o_val,
  input  logic      i_rdy,
  output fe2_t      o_f,
  // Product requests to the shared multiplier
  fp_mul_if.source  o_req,
  // Returned products
  input  logic      i_res_val,
  input  fe_t       i_res_dat,
  input  prod_tag_e i_res_tag
);

  ctrl_state_e                   state;
  logic [$clog2(LOOP_TOP)-1:0]   bit_idx;  // Exponent bit of the current step
  logic                          step_mul; // Current step is f*g, else f^2
  logic [1:0]                    iss_cnt;  // Requests issued in this step
  logic [3:0]                    got_q;    // One bit per received tag
  logic [3:0]                    need;
  fe_t                           prod_q [4];
  fe2_t                          g_q;
  fe2_t                          f_q;
  prod_tag_e                     iss_tag;
  logic                          last_iss;
  logic                          accept;
  logic                          step_done;

  // Modular add, both operands below P
  function automatic fe_t fe_add(input fe_t x, input fe_t y);
    logic [FE_BITS:0] s;
    s = {1'b0, x} + {1'b0, y};
    if (s >= {1'b0, FE_P}) begin
      s = s - {1'b0, FE_P};
    end
    return s[FE_BITS-1:0];
  endfunction

  // Modular subtract, both operands below P
  function automatic fe_t fe_sub(input fe_t x, input fe_t y);
    fe_t d;
    if (x >= y) begin
      d = x - y;
    end else begin
      d = x + (FE_P - y);  // Stays below P, no wrap
    end
    return d;
  endfunction

  assign iss_tag   = prod_tag_e'(iss_cnt);
  assign need      = step_mul ? 4'b1111 : 4'b0111;  // Square never asks for TAG_IR
  assign last_iss  = step_mul ? (iss_cnt == 2'd3) : (iss_cnt == 2'd2);
  assign accept    = (state == ST_IDLE) && i_val && o_rdy;
  assign step_done = (state == ST_WAIT) && (got_q == need);

  assign o_val = (state == ST_OUT);
  assign o_f   = f_q;  // f is frozen while in ST_OUT

  // Request operands follow the issue counter
  always_comb begin
    o_req.val = (state == ST_SQR) || (state == ST_MUL);
    o_req.tag = iss_tag;
    case (iss_tag)
      TAG_RR: begin
        o_req.a = f_q.re;
        o_req.b = step_mul ? g_q.re : f_q.re;
      end
      TAG_II: begin
        o_req.a = f_q.im;
        o_req.b = step_mul ? g_q.im : f_q.im;
      end
      TAG_RI: begin
        o_req.a = f_q.re;
        o_req.b = step_mul ? g_q.im : f_q.im;
      end
      default: begin
        o_req.a = f_q.im;
        o_req.b = g_q.re;
      end
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state    <= ST_IDLE;
      o_rdy    <= 1'b0;
      bit_idx  <= '0;
      step_mul <= 1'b0;
      iss_cnt  <= 2'd0;
      got_q    <= 4'd0;
    end else begin
      if (i_res_val) begin
        got_q[i_res_tag] <= 1'b1;
      end

      case (state)
        ST_IDLE: begin
          o_rdy <= 1'b1;
          if (accept) begin
            o_rdy    <= 1'b0;
            bit_idx  <= ($clog2(LOOP_TOP))'(LOOP_TOP - 1);
            step_mul <= 1'b0;
            iss_cnt  <= 2'd0;
            state    <= ST_SQR;
          end
        end
        ST_SQR, ST_MUL: begin
          if (o_req.val && o_req.rdy) begin
            iss_cnt <= iss_cnt + 2'd1;
            if (last_iss) begin
              state <= ST_WAIT;
            end
          end
        end
        ST_WAIT: begin
          if (step_done) begin
            got_q   <= 4'd0;  // Every issued product is in, nothing else can arrive
            iss_cnt <= 2'd0;
            if (!step_mul && LOOP_X[bit_idx]) begin
              step_mul <= 1'b1;
              state    <= ST_MUL;
            end else if (bit_idx == '0) begin
              state <= ST_OUT;
            end else begin
              bit_idx  <= bit_idx - 1'b1;
              step_mul <= 1'b0;
              state    <= ST_SQR;
            end
          end
        end
        ST_OUT: begin
          if (i_rdy) begin
            o_rdy <= 1'b1;
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Operand and product storage
  always_ff @(posedge i_clk) begin
    if (accept) begin
      g_q <= i_g;
      f_q <= i_g;  // Loop starts from f = g
    end else if (step_done) begin
      f_q.re <= fe_sub(prod_q[TAG_RR], prod_q[TAG_II]);
      // Square gives 2*re*im, multiply gives re*g.im + im*g.re
      f_q.im <= fe_add(prod_q[TAG_RI], step_mul ? prod_q[TAG_IR] : prod_q[TAG_RI]);
    end
    if (i_res_val) begin
      prod_q[i_res_tag] <= i_res_dat;
    end
  end

endmodule

// ==== hw/mul_req_fifo.sv ====
/*
  Four-entry request FIFO between the controller and the multiplier.
  rdy drops only when all entries are full; a write into an empty FIFO
  is visible at the output one cycle later.
*/
`timescale 1ns/1ps

module mul_req_fifo import fp2_exp_pkg::*; (
  input  logic     i_clk,
  input  logic     i_rst,
  fp_mul_if.sink   i_req,
  fp_mul_if.source o_req
);

  fe_t       a_mem   [FIFO_DEPTH];
  fe_t       b_mem   [FIFO_DEPTH];
  prod_tag_e tag_mem [FIFO_DEPTH];

  logic [1:0] wr_ptr;  // Wraps naturally at depth 4
  logic [1:0] rd_ptr;
  logic [2:0] count;
  logic       wr_en;
  logic       rd_en;

  assign i_req.rdy = (count != 3'(FIFO_DEPTH));
  assign wr_en     = i_req.val && i_req.rdy;

  assign o_req.val = (count != 3'd0);
  assign o_req.a   = a_mem[rd_ptr];
  assign o_req.b   = b_mem[rd_ptr];
  assign o_req.tag = tag_mem[rd_ptr];
  assign rd_en     = o_req.val && o_req.rdy;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= 2'd0;
      rd_ptr <= 2'd0;
      count  <= 3'd0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      count <= count + {2'd0, wr_en} - {2'd0, rd_en};  // Push and pop may share a cycle
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_en) begin
      a_mem[wr_ptr]   <= i_req.a;
      b_mem[wr_ptr]   <= i_req.b;
      tag_mem[wr_ptr] <= i_req.tag;
    end
  end

endmodule

// ==== hw/fp_mul_mersenne.sv ====
/*
  Multiplier modulo 2^13 - 1 with one 13x7 partial product unit.
  A new pair is taken every second cycle, the product appears 3 cycles
  after the accept edge. Operands must be below P.
*/
`timescale 1ns/1ps

module fp_mul_mersenne import fp2_exp_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  fp_mul_if.sink    i_req,
  output logic      o_res_val,
  output fe_t       o_res_dat,
  output prod_tag_e o_res_tag
);

  // Stage 1, low partial product done, high half of b pending
  logic             s1_val;
  fe_t              s1_a;
  logic [5:0]       s1_bhi;
  logic [19:0]      s1_acc;
  prod_tag_e        s1_tag;
  // Stage 2, full 26 bit product
  logic             s2_val;
  logic [25:0]      s2_prod;
  prod_tag_e        s2_tag;
  // Stage 3, folded sum below 2P
  logic             s3_val;
  logic [FE_BITS:0] s3_fold;
  prod_tag_e        s3_tag;

  fe_t         mul_a;
  logic [6:0]  mul_b;
  logic [19:0] pp;
  logic        accept;

  assign i_req.rdy = !s1_val;  // Partial product unit busy with the high half
  assign accept    = i_req.val && i_req.rdy;

  // Shared partial product, low half of b on accept, high half a cycle later
  always_comb begin
    mul_a = s1_val ? s1_a : i_req.a;
    mul_b = s1_val ? {1'b0, s1_bhi} : i_req.b[6:0];
    pp    = {7'd0, mul_a} * {13'd0, mul_b};
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      s1_val    <= 1'b0;
      s2_val    <= 1'b0;
      s3_val    <= 1'b0;
      o_res_val <= 1'b0;
    end else begin
      s1_val    <= accept;
      s2_val    <= s1_val;
      s3_val    <= s2_val;
      o_res_val <= s3_val;
    end
  end

  always_ff @(posedge i_clk) begin
    s1_a    <= i_req.a;
    s1_bhi  <= i_req.b[12:7];
    s1_acc  <= pp;
    s1_tag  <= i_req.tag;

    s2_prod <= {6'd0, s1_acc} + {pp[18:0], 7'd0};  // a*b_hi fits in 19 bits
    s2_tag  <= s1_tag;

    // 2^13 = 1 mod P, so the high word folds onto the low word
    s3_fold <= {1'b0, s2_prod[FE_BITS-1:0]} + {1'b0, s2_prod[2*FE_BITS-1:FE_BITS]};
    s3_tag  <= s2_tag;

    if (s3_fold >= {1'b0, FE_P}) begin
      o_res_dat <= fe_t'(s3_fold - {1'b0, FE_P});
    end else begin
      o_res_dat <= s3_fold[FE_BITS-1:0];
    end
    o_res_tag <= s3_tag;
  end

endmodule

// ==== hw/fp2_exp_top.sv ====
/*
  Fp2 exponentiation engine, computes g^0xD201 with g = re + im*u mod 8191.
  Latency varies with the exponent walk; o_val marks the end.
*/
`timescale 1ns/1ps

module fp2_exp_top import fp2_exp_pkg::*; (
  input  logic i_clk,
  input  logic i_rst,
  // Input element
  input  logic i_val,
  output logic o_rdy,
  input  fe_t  i_g_re,
  input  fe_t  i_g_im,
  // Result element
  output logic o_val,
  input  logic i_rdy,
  output fe_t  o_f_re,
  output fe_t  o_f_im
);

  fp_mul_if req_ctrl ();  // Controller to FIFO
  fp_mul_if req_mul ();   // FIFO to multiplier

  logic      res_val;
  fe_t       res_dat;
  prod_tag_e res_tag;
  fe2_t      g_in;
  fe2_t      f_out;

  assign g_in   = '{re: i_g_re, im: i_g_im};
  assign o_f_re = f_out.re;
  assign o_f_im = f_out.im;

  fp2_exp_ctrl u_ctrl (
    .i_clk     ( i_clk    ),
    .i_rst     ( i_rst    ),
    .i_val     ( i_val    ),
    .o_rdy     ( o_rdy    ),
    .i_g       ( g_in     ),
    .o_val     ( o_val    ),
    .i_rdy     ( i_rdy    ),
    .o_f       ( f_out    ),
    .o_req     ( req_ctrl ),
    .i_res_val ( res_val  ),
    .i_res_dat ( res_dat  ),
    .i_res_tag ( res_tag  )
  );

  mul_req_fifo u_fifo (
    .i_clk ( i_clk    ),
    .i_rst ( i_rst    ),
    .i_req ( req_ctrl ),
    .o_req ( req_mul  )
  );

  fp_mul_mersenne u_mul (
    .i_clk     ( i_clk   ),
    .i_rst     ( i_rst   ),
    .i_req     ( req_mul ),
    .o_res_val ( res_val ),
    .o_res_dat ( res_dat ),
    .o_res_tag ( res_tag )
  );

endmodule

// ==== sim/fp2_exp_assert.sv ====
/*
  Protocol checks bound into the Fp2 exponentiation top level.
  Request valids are read from the two internal request interfaces.
*/
`timescale 1ns/1ps

module fp2_exp_assert import fp2_exp_pkg::*; (
  input logic i_clk,
  input logic i_rst,
  input logic i_in_val,
  input logic i_in_rdy,
  input logic i_out_val,
  input logic i_out_rdy,
  input fe_t  i_f_re,
  input fe_t  i_f_im,
  input logic i_ctrl_val,  // Controller to FIFO request
  input logic i_mul_val,   // FIFO to multiplier request
  input logic i_mul_rdy
);

  logic seen_in;       // First input taken since reset
  int   fail_cnt = 0;  // Count of failed assertions for the run summary

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      seen_in <= 1'b0;
    end else if (i_in_val && i_in_rdy) begin
      seen_in <= 1'b1;
    end
  end

  a_out_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val && !i_out_rdy |=> i_out_val && $stable(i_f_re) && $stable(i_f_im))
    else begin
      $error("Output result changed while i_rdy was low");
      fail_cnt++;
    end

  a_rdy_busy: assert property (@(posedge i_clk) disable iff (i_rst)
    i_out_val |-> !i_in_rdy)
    else begin
      $error("o_rdy high while o_val is high");
      fail_cnt++;
    end

  a_mul_gap: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_val && i_mul_rdy |=> !i_mul_rdy)
    else begin
      $error("Multiplier ready in the cycle after an accept");
      fail_cnt++;
    end

  a_no_early_req: assert property (@(posedge i_clk) disable iff (i_rst)
    !seen_in |-> !i_ctrl_val && !i_mul_val)
    else begin
      $error("Multiply request before the first input");
      fail_cnt++;
    end

endmodule

bind fp2_exp_top fp2_exp_assert u_assert (
  .i_clk      ( i_clk        ),
  .i_rst      ( i_rst        ),
  .i_in_val   ( i_val        ),
  .i_in_rdy   ( o_rdy        ),
  .i_out_val  ( o_val        ),
  .i_out_rdy  ( i_rdy        ),
  .i_f_re     ( o_f_re       ),
  .i_f_im     ( o_f_im       ),
  .i_ctrl_val ( req_ctrl.val ),
  .i_mul_val  ( req_mul.val  ),
  .i_mul_rdy  ( req_mul.rdy  )
);

// ==== sim/tb_fp2_exp.sv ====
/*
  Table driven testbench for the Fp2 exponentiation engine.
  Rows may stall the output or arrive while the previous row is busy.
*/
`timescale 1ns/1ps

module tb_fp2_exp import fp2_exp_pkg::*; ();

  localparam int NUM_FIXED    = 7;
  localparam int NUM_RAND     = 8;
  localparam int NUM_TESTS    = NUM_FIXED + NUM_RAND;
  localparam int MOD          = int'(FE_P);
  localparam int CYC_PER_TEST = 400;
  localparam int WATCHDOG_NS  = (NUM_TESTS * CYC_PER_TEST + 100) * 8;

  logic i_clk = 1'b0;
  logic i_rst;
  logic i_val;
  logic o_rdy;
  fe_t  i_g_re;
  fe_t  i_g_im;
  logic o_val;
  logic i_rdy;
  fe_t  o_f_re;
  fe_t  o_f_im;

  string tab_name  [NUM_TESTS];
  int    tab_re    [NUM_TESTS];
  int    tab_im    [NUM_TESTS];
  int    tab_stall [NUM_TESTS];  // Cycles of i_rdy low once o_val is up
  bit    tab_b2b   [NUM_TESTS];  // Presented while the previous row is busy

  int seed = 27;
  int n_pass;
  int n_fail;

  fp2_exp_top i_dut (
    .i_clk  ( i_clk  ),
    .i_rst  ( i_rst  ),
    .i_val  ( i_val  ),
    .o_rdy  ( o_rdy  ),
    .i_g_re ( i_g_re ),
    .i_g_im ( i_g_im ),
    .o_val  ( o_val  ),
    .i_rdy  ( i_rdy  ),
    .o_f_re ( o_f_re ),
    .o_f_im ( o_f_im )
  );

  always #4 i_clk = ~i_clk;

  task automatic set_row(input int idx, input string name, input int re, input int im,
                         input int stall, input bit b2b);
    tab_name[idx]  = name;
    tab_re[idx]    = re;
    tab_im[idx]    = im;
    tab_stall[idx] = stall;
    tab_b2b[idx]   = b2b;
  endtask

  task automatic fill_table();
    int r_re;
    int r_im;
    int r_st;
    set_row(0, "one",       1,    0,    0, 1'b0);
    set_row(1, "zero",      0,    0,    0, 1'b1);
    set_row(2, "unit_u",    0,    1,    0, 1'b0);
    set_row(3, "real_two",  2,    0,    0, 1'b1);
    set_row(4, "real_pm1",  8190, 0,    0, 1'b0);
    set_row(5, "stall_3",   1234, 4321, 3, 1'b0);
    set_row(6, "stall_b2b", 77,   8000, 7, 1'b1);
    for (int i = 0; i < NUM_RAND; i++) begin
      r_re = int'($unsigned($random(seed)) % MOD);
      r_im = int'($unsigned($random(seed)) % MOD);
      r_st = int'($unsigned($random(seed)) % 6);
      set_row(NUM_FIXED + i, $sformatf("rand_%0d", i), r_re, r_im, r_st, (i % 2) == 1);
    end
  endtask

  // Square and multiply over Fp2 with u^2 = -1
  task automatic pow_reference(input int g_re, input int g_im,
                               output fe_t r_re, output fe_t r_im);
    int re;
    int im;
    int t_re;
    int t_im;
    int b;
    re = g_re;
    im = g_im;
    for (b = LOOP_TOP - 1; b >= 0; b--) begin
      t_re = ((re * re) % MOD - (im * im) % MOD + MOD) % MOD;
      t_im = (2 * ((re * im) % MOD)) % MOD;
      re   = t_re;
      im   = t_im;
      if (LOOP_X[b]) begin
        t_re = ((re * g_re) % MOD - (im * g_im) % MOD + MOD) % MOD;
        t_im = ((re * g_im) % MOD + (im * g_re) % MOD) % MOD;
        re   = t_re;
        im   = t_im;
      end
    end
    r_re = fe_t'(re);
    r_im = fe_t'(im);
  endtask

  task automatic present_row(input int idx);
    i_val  <= 1'b1;
    i_g_re <= fe_t'(tab_re[idx]);
    i_g_im <= fe_t'(tab_im[idx]);
  endtask

  task automatic wait_accept();
    do begin
      @(posedge i_clk);
    end while (!(i_val && o_rdy));
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the engine did not finish all rows in %0d ns", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

  initial begin
    bit  accepted;
    bit  ok;
    bit  done;
    bit  seen;
    bit  rdy_err;
    int  stall_cnt;
    fe_t held_re;
    fe_t held_im;
    fe_t exp_re;
    fe_t exp_im;
    i_rst  <= 1'b1;
    i_val  <= 1'b0;
    i_rdy  <= 1'b1;
    i_g_re <= '0;
    i_g_im <= '0;
    n_pass = 0;
    n_fail = 0;
    fill_table();
    repeat (8) @(posedge i_clk);
    i_rst <= 1'b0;
    accepted = 1'b0;
    present_row(0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      if (!accepted) begin
        wait_accept();
      end
      // Just after the accept edge of row t
      if (t + 1 < NUM_TESTS && tab_b2b[t + 1]) begin
        present_row(t + 1);
      end else begin
        i_val <= 1'b0;
      end
      i_rdy <= (tab_stall[t] == 0);
      pow_reference(tab_re[t], tab_im[t], exp_re, exp_im);
      ok        = 1'b1;
      done      = 1'b0;
      seen      = 1'b0;
      rdy_err   = 1'b0;
      stall_cnt = 0;
      while (!done) begin
        @(posedge i_clk);
        if (o_rdy && !rdy_err) begin
          $display("Error in %s: o_rdy is high while a result is pending", tab_name[t]);
          rdy_err = 1'b1;
          ok      = 1'b0;
        end
        if (o_val) begin
          if (!seen) begin
            held_re = o_f_re;
            held_im = o_f_im;
            seen    = 1'b1;
          end else if (o_f_re != held_re || o_f_im != held_im) begin
            $display("Error in %s: result changed while i_rdy was low", tab_name[t]);
            ok = 1'b0;
          end
          if (i_rdy) begin
            done = 1'b1;  // Transfer edge
          end else begin
            stall_cnt++;
            if (stall_cnt >= tab_stall[t]) begin
              i_rdy <= 1'b1;
            end
          end
        end
      end
      if (o_f_re != exp_re || o_f_im != exp_im) begin
        $display("Mismatch %s: expected %0d + %0du, actual %0d + %0du",
                 tab_name[t], exp_re, exp_im, o_f_re, o_f_im);
        ok = 1'b0;
      end
      if (tab_im[t] == 0 && o_f_im != '0) begin
        $display("Mismatch %s_imag: expected 0, actual %0d", tab_name[t], o_f_im);
        ok = 1'b0;
      end
      @(posedge i_clk);
      if (!o_rdy) begin
        $display("Error in %s: o_rdy did not rise after the output transfer", tab_name[t]);
        ok = 1'b0;
      end
      accepted = i_val && o_rdy;  // A waiting row is taken on this edge
      if (!accepted && t + 1 < NUM_TESTS) begin
        present_row(t + 1);
      end
      if (ok) begin
        n_pass++;
      end else begin
        n_fail++;
      end
      $display("Test %s stall %0d  %s", tab_name[t], tab_stall[t], ok ? "passed" : "failed");
    end
    i_val <= 1'b0;
    if (i_dut.u_assert.fail_cnt != 0) begin
      $display("Error: %0d protocol assertions failed during the run",
               i_dut.u_assert.fail_cnt);
    end
    $display("Tests run %0d, passed %0d, failed %0d", NUM_TESTS, n_pass, n_fail);
    if (n_fail == 0 && i_dut.u_assert.fail_cnt == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hw/fp2_exp_pkg.sv
hw/fp_mul_if.sv
hw/fp2_exp_ctrl.sv
hw/mul_req_fifo.sv
hw/fp_mul_mersenne.sv
hw/fp2_exp_top.sv
sim/fp2_exp_assert.sv
sim/tb_fp2_exp.sv

// ==== run.sh ====
#!/bin/sh
# Builds the Fp2 exponentiation testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module tb_fp2_exp -f list.f -o tb_fp2_exp \
  > build.log 2>&1 \
  && ./obj_dir/tb_fp2_exp > sim.log 2>&1 \
  || { echo "Build or simulation stopped early"; cat build.log sim.log 2>/dev/null; }
grep -q "RESULT: PASS" sim.log 2>/dev/null && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }
